// ==== Bender.yml ====
package:
  name: dual_issue_ctrl

sources:
  - src/spu_pkg.sv
  - src/instr_decode.sv
  - src/stage_tracker.sv
  - src/hazard_unit.sv
  - src/dual_issue_ctrl.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_dual_issue.sv

// ==== bench/issue_model.svh ====
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// one slot as the model sees it, src[0] is ra.
typedef struct packed {
  logic            valid;
  logic            pipe;
  logic [6:0]      dst;
  logic [2:0][6:0] src;
  logic [2:0]      used;
  logic [2:0]      lat;
} slot_info_t;

spu_pkg::stage_rec_t shadow_even [1:DEPTH];
spu_pkg::stage_rec_t shadow_odd  [1:DEPTH];
spu_pkg::stage_rec_t exp_even;
spu_pkg::stage_rec_t exp_odd;
logic                exp_take0;
logic                exp_take1;

// word layout is op[31:28], rt, ra, rb, rc.
function automatic slot_info_t decode_word(input logic [31:0] w, input logic v);
  slot_info_t s;
  s.valid  = v;
  s.pipe   = w[28];
  s.dst    = w[27:21];
  s.src[0] = w[20:14];
  s.src[1] = w[13:7];
  s.src[2] = w[6:0];
  // immediate form only reads ra.
  s.used   = w[31] ? 3'b001 : 3'b111;
  if (!v) begin
    s.used = 3'b000;
  end
  s.lat = 3'd2 + {1'b0, w[30:29]};
  return s;
endfunction

function automatic logic reads_reg(input slot_info_t s, input logic [6:0] r);
  logic hit;
  hit = 1'b0;
  for (int i = 0; i < 3; i++) begin
    if (s.used[i] && s.src[i] == r) begin
      hit = 1'b1;
    end
  end
  return hit;
endfunction

// producer in stage k is still busy while its latency exceeds k.
function automatic logic stalled_by_shadow(input slot_info_t s);
  logic hit;
  hit = 1'b0;
  for (int k = 1; k <= DEPTH; k++) begin
    if (shadow_even[k].valid && int'(shadow_even[k].latency) > k &&
        reads_reg(s, shadow_even[k].dst)) begin
      hit = 1'b1;
    end
    if (shadow_odd[k].valid && int'(shadow_odd[k].latency) > k &&
        reads_reg(s, shadow_odd[k].dst)) begin
      hit = 1'b1;
    end
  end
  return hit;
endfunction

function automatic spu_pkg::stage_rec_t make_rec(input slot_info_t s);
  spu_pkg::stage_rec_t r;
  r.valid   = 1'b1;
  r.dst     = s.dst;
  r.latency = s.lat;
  return r;
endfunction

task automatic predict_issue(input slot_info_t s0, input slot_info_t s1);
  exp_take0 = s0.valid && !stalled_by_shadow(s0);
  exp_take1 = exp_take0 && s1.valid && (s1.pipe != s0.pipe) &&
              !reads_reg(s1, s0.dst) && (s1.dst != s0.dst) && !stalled_by_shadow(s1);
  exp_even = '0;
  exp_odd  = '0;
  if (exp_take0) begin
    if (s0.pipe) exp_odd = make_rec(s0);
    else exp_even = make_rec(s0);
  end
  if (exp_take1) begin
    if (s1.pipe) exp_odd = make_rec(s1);
    else exp_even = make_rec(s1);
  end
endtask

// shadow pipes move on the model's own issues.
task automatic advance_shadow();
  for (int k = DEPTH; k >= 2; k--) begin
    shadow_even[k] = shadow_even[k-1];
    shadow_odd[k]  = shadow_odd[k-1];
  end
  shadow_even[1] = exp_even;
  shadow_odd[1]  = exp_odd;
endtask

task automatic clear_shadow();
  for (int k = 1; k <= DEPTH; k++) begin
    shadow_even[k] = '0;
    shadow_odd[k]  = '0;
  end
endtask

`endif

// ==== bench/tb_dual_issue.sv ====
`timescale 1ns/1ps

module tb_dual_issue;

  localparam int DEPTH = 6;
  localparam int RESET_CYCLES = 3;
  localparam int NUM_PAIRS = 2000;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_PAIRS + 97;

  logic                clk;
  logic                reset;
  logic                valid0;
  logic                valid1;
  spu_pkg::spu_instr_u instr0;
  spu_pkg::spu_instr_u instr1;
  logic                take0;
  logic                take1;
  spu_pkg::stage_rec_t even_issue;
  spu_pkg::stage_rec_t odd_issue;

  integer      seed;
  int          value_errors;
  int          protocol_errors;
  int          progress_errors;
  int          dut_takes;
  int          model_takes;
  int          stall_run;
  int          cycles;
  logic        seen_take0;
  logic        seen_take1;
  logic [31:0] fetch_q [$];

  `include "issue_model.svh"

  dual_issue_ctrl #(
    .DEPTH (DEPTH)
  ) dut0 (
    .clk        (clk),
    .reset      (reset),
    .valid0     (valid0),
    .instr0     (instr0),
    .valid1     (valid1),
    .instr1     (instr1),
    .take0      (take0),
    .take1      (take1),
    .even_issue (even_issue),
    .odd_issue  (odd_issue)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // registers 0 to 7 only, so hazards come often.
  function automatic logic [31:0] random_word();
    logic [31:0] r;
    r = $random(seed);
    return {r[3:0], 4'b0, r[6:4], 4'b0, r[9:7], 4'b0, r[12:10], 4'b0, r[15:13]};
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    value_errors++;
    $display("[FAIL] %s got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cycles);
  endtask

  task automatic check_cycle();
    slot_info_t s0;
    slot_info_t s1;
    s0 = decode_word(instr0, valid0);
    s1 = decode_word(instr1, valid1);
    predict_issue(s0, s1);
    assert (take0 === exp_take0) else report_value("take0", take0, exp_take0);
    assert (take1 === exp_take1) else report_value("take1", take1, exp_take1);
    assert (even_issue === exp_even) else report_value("even_issue", even_issue, exp_even);
    assert (odd_issue === exp_odd) else report_value("odd_issue", odd_issue, exp_odd);
    assert (take0 || !take1) else begin
      protocol_errors++;
      $display("take1 was raised while take0 was low at cycle %0d", cycles);
    end
    assert (valid0 || (!even_issue.valid && !odd_issue.valid)) else begin
      protocol_errors++;
      $display("an issue record was valid with no slot 0 at cycle %0d", cycles);
    end
    if (valid0 && !take0) stall_run++;
    else if (take0) stall_run = 0;
    assert (stall_run != spu_pkg::MAX_LAT + 1) else begin
      progress_errors++;
      $display("issue made no progress, slot 0 stuck for %0d cycles", stall_run);
    end
    seen_take0  = take0;
    seen_take1  = take1;
    dut_takes   = dut_takes + int'(take0) + int'(take1);
    model_takes = model_takes + int'(exp_take0) + int'(exp_take1);
  endtask

  initial begin
    logic [31:0] drop;
    seed            = 37412;
    value_errors    = 0;
    protocol_errors = 0;
    progress_errors = 0;
    dut_takes       = 0;
    model_takes     = 0;
    stall_run       = 0;
    reset           = 1'b1;
    valid0          = 1'b0;
    valid1          = 1'b0;
    instr0          = '0;
    instr1          = '0;
    clear_shadow();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    for (int n = 0; n < NUM_PAIRS; n++) begin
      while (fetch_q.size() < 2) begin
        fetch_q.push_back(random_word());
      end
      // each slot goes quiet about one cycle in eight.
      drop = $random(seed);
      valid0 <= (drop[2:0] != 3'd0);
      valid1 <= (drop[5:3] != 3'd0);
      instr0 <= fetch_q[0];
      instr1 <= fetch_q[1];
      @(negedge clk);
      check_cycle();
      @(posedge clk);
      advance_shadow();
      // a lone take0 moves slot 1 up to slot 0.
      if (seen_take0) begin
        void'(fetch_q.pop_front());
        if (seen_take1) void'(fetch_q.pop_front());
      end
    end
    assert (dut_takes == model_takes) else report_value("take count", dut_takes, model_takes);
    $display("errors: value %0d, protocol %0d, progress %0d, takes %0d",
             value_errors, protocol_errors, progress_errors, dut_takes);
    if (value_errors + protocol_errors + progress_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+bench
src/spu_pkg.sv
src/instr_decode.sv
src/stage_tracker.sv
src/hazard_unit.sv
src/dual_issue_ctrl.sv
bench/tb_dual_issue.sv

// ==== src/dual_issue_ctrl.sv ====
`timescale 1ns/1ps

module dual_issue_ctrl #(
  parameter int DEPTH = 6
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                valid0,
  input  spu_pkg::spu_instr_u instr0,
  input  logic                valid1,
  input  spu_pkg::spu_instr_u instr1,
  output logic                take0,
  output logic                take1,
  output spu_pkg::stage_rec_t even_issue,
  output spu_pkg::stage_rec_t odd_issue
);

  spu_pkg::decoded_t   dec0;
  spu_pkg::decoded_t   dec1;
  spu_pkg::stage_rec_t even_stages [1:DEPTH];
  spu_pkg::stage_rec_t odd_stages  [1:DEPTH];

  // slot 0 is the older instruction.
  instr_decode dec_slot0 (
    .instr (instr0),
    .valid (valid0),
    .dec   (dec0)
  );

  instr_decode dec_slot1 (
    .instr (instr1),
    .valid (valid1),
    .dec   (dec1)
  );

  hazard_unit #(
    .DEPTH (DEPTH)
  ) hazard (
    .dec0        (dec0),
    .dec1        (dec1),
    .even_stages (even_stages),
    .odd_stages  (odd_stages),
    .take0       (take0),
    .take1       (take1),
    .even_issue  (even_issue),
    .odd_issue   (odd_issue)
  );

  // in-flight records per pipe.
  stage_tracker #(
    .DEPTH (DEPTH)
  ) even_track (
    .clk    (clk),
    .reset  (reset),
    .issue  (even_issue),
    .stages (even_stages)
  );

  stage_tracker #(
    .DEPTH (DEPTH)
  ) odd_track (
    .clk    (clk),
    .reset  (reset),
    .issue  (odd_issue),
    .stages (odd_stages)
  );

endmodule

// ==== src/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit #(
  parameter int DEPTH = 6
) (
  input  spu_pkg::decoded_t   dec0,
  input  spu_pkg::decoded_t   dec1,
  input  spu_pkg::stage_rec_t even_stages [1:DEPTH],
  input  spu_pkg::stage_rec_t odd_stages  [1:DEPTH],
  output logic                take0,
  output logic                take1,
  output spu_pkg::stage_rec_t even_issue,
  output spu_pkg::stage_rec_t odd_issue
);

  logic raw0;
  logic raw1;
  logic reads_dst0;
  logic pair_ok;
  logic even_from0;
  logic even_from1;
  logic odd_from0;
  logic odd_from1;

  // true when the stage holds a producer of a used source still in flight.
  function automatic logic blocks(spu_pkg::decoded_t d, spu_pkg::stage_rec_t s, int k);
    logic reads;
    reads = (d.ra_use && d.ra == s.dst) ||
            (d.rb_use && d.rb == s.dst) ||
            (d.rc_use && d.rc == s.dst);
    return s.valid && reads && (int'(s.latency) > k);
  endfunction

  function automatic spu_pkg::stage_rec_t to_rec(spu_pkg::decoded_t d);
    spu_pkg::stage_rec_t rec;
    rec.valid   = 1'b1;
    rec.dst     = d.dst;
    rec.latency = d.latency;
    return rec;
  endfunction

  // raw check against every stage of both pipes.
  always_comb begin
    raw0 = 1'b0;
    raw1 = 1'b0;
    for (int k = 1; k <= DEPTH; k++) begin
      raw0 = raw0 | blocks(dec0, even_stages[k], k) | blocks(dec0, odd_stages[k], k);
      raw1 = raw1 | blocks(dec1, even_stages[k], k) | blocks(dec1, odd_stages[k], k);
    end
  end

  // slot 1 may not consume what slot 0 produces this cycle.
  assign reads_dst0 = (dec1.ra_use && dec1.ra == dec0.dst) ||
                      (dec1.rb_use && dec1.rb == dec0.dst) ||
                      (dec1.rc_use && dec1.rc == dec0.dst);

  assign pair_ok = dec1.valid && (dec1.pipe != dec0.pipe) &&
                   !reads_dst0 && (dec1.dst != dec0.dst);

  assign take0 = dec0.valid && !raw0;
  assign take1 = take0 && pair_ok && !raw1;

  // steering to the pipe named by each slot.
  assign even_from0 = take0 && (dec0.pipe == spu_pkg::even);
  assign even_from1 = take1 && (dec1.pipe == spu_pkg::even);
  assign odd_from0  = take0 && (dec0.pipe == spu_pkg::odd);
  assign odd_from1  = take1 && (dec1.pipe == spu_pkg::odd);

  always_comb begin
    even_issue = '0;
    odd_issue  = '0;
    if (even_from0) begin
      even_issue = to_rec(dec0);
    end else if (even_from1) begin
      even_issue = to_rec(dec1);
    end
    if (odd_from0) begin
      odd_issue = to_rec(dec0);
    end else if (odd_from1) begin
      odd_issue = to_rec(dec1);
    end
  end

endmodule

// ==== src/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
  input  spu_pkg::spu_instr_u instr,
  input  logic                valid,
  output spu_pkg::decoded_t   dec
);

  // every opcode takes at least two cycles.
  localparam int LAT_BASE = 2;

  logic       is_imm;
  logic [3:0] op;

  // op sits at the same place in both views.
  assign op     = instr.ri.op;
  assign is_imm = op[3];

  always_comb begin
    dec = '0;

    dec.valid   = valid;
    dec.pipe    = spu_pkg::pipe_e'(op[0]);
    dec.latency = spu_pkg::lat_t'(LAT_BASE) + {1'b0, op[2:1]};

    // rt and ra share their place in both views.
    dec.dst    = instr.rrr.rt;
    dec.ra     = instr.rrr.ra;
    dec.ra_use = valid;

    // immediate form reads ra only.
    if (!is_imm) begin
      dec.rb     = instr.rrr.rb;
      dec.rb_use = valid;
      dec.rc     = instr.rrr.rc;
      dec.rc_use = valid;
    end
  end

endmodule

// ==== src/spu_pkg.sv ====
package spu_pkg;

  // largest producer latency any opcode can carry.
  localparam int MAX_LAT = 5;

  // register number, 128 registers per file.
  typedef logic [6:0] reg_addr_t;

  // producer latency in cycles.
  typedef logic [2:0] lat_t;

  // three-source view of an instruction word.
  typedef struct packed {
    logic [3:0] op;
    reg_addr_t  rt;
    reg_addr_t  ra;
    reg_addr_t  rb;
    reg_addr_t  rc;
  } instr_rrr_t;

  // immediate view of the same word.
  typedef struct packed {
    logic [3:0]  op;
    reg_addr_t   rt;
    reg_addr_t   ra;
    logic [13:0] imm;
  } instr_ri_t;

  // op bit 3 picks which view is meaningful.
  typedef union packed {
    instr_rrr_t rrr;
    instr_ri_t  ri;
  } spu_instr_u;

  typedef enum logic {
    even = 1'b0,
    odd  = 1'b1
  } pipe_e;

  // one decoded slot.
  typedef struct packed {
    logic      valid;
    pipe_e     pipe;
    reg_addr_t dst;
    reg_addr_t ra;
    logic      ra_use;
    reg_addr_t rb;
    logic      rb_use;
    reg_addr_t rc;
    logic      rc_use;
    lat_t      latency;
  } decoded_t;

  // one in-flight record in a pipe stage.
  typedef struct packed {
    logic      valid;
    reg_addr_t dst;
    lat_t      latency;
  } stage_rec_t;

endpackage

// ==== src/stage_tracker.sv ====
`timescale 1ns/1ps

module stage_tracker #(
  parameter int DEPTH = 6
) (
  input  logic                clk,
  input  logic                reset,
  input  spu_pkg::stage_rec_t issue,
  output spu_pkg::stage_rec_t stages [1:DEPTH]
);

  // a record has to stay visible until its latency has run out.
  if (DEPTH < spu_pkg::MAX_LAT) begin : g_depth_check
    $error("stage_tracker DEPTH %0d shorter than MAX_LAT %0d", DEPTH, spu_pkg::MAX_LAT);
  end

  // stage k holds the record issued k cycles ago.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 1; k <= DEPTH; k++) begin
        stages[k] <= '0;
      end
    end else begin
      stages[1] <= issue;
      for (int k = 2; k <= DEPTH; k++) begin
        stages[k] <= stages[k-1];
      end
    end
  end

  // an entering producer must retire before it falls off the end.
  a_lat_fits : assert property (
    @(posedge clk) disable iff (reset)
    issue.valid |-> (int'(issue.latency) <= DEPTH)
  ) else $error("stage_tracker latency %0d exceeds depth %0d", issue.latency, DEPTH);

endmodule
